//--- Makefile
TOP = eth_rx_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- hdl/eth_rx_buffer.sv
module eth_rx_buffer (
   input  logic                              MRxClk,
   input  logic                              wr_en_i,
   input  logic [3:0]                        wr_strb_i,
   input  logic [eth_rx_pkg::BUF_ADDR_W-1:0] wr_addr_i,
   input  logic [31:0]                       wr_data_i,
   input  logic                              rd_en_i,
   input  logic [eth_rx_pkg::BUF_ADDR_W-1:0] rd_addr_i,
   output logic [31:0]                       rd_data_o
);
   import eth_rx_pkg::*;

   logic [31:0] mem [0:BUF_WORDS-1];

   // Write port, one enable per byte lane
   always_ff @(posedge MRxClk) begin
      if (wr_en_i) begin
         for (int i = 0; i < 4; i++) begin
            if (wr_strb_i[i])
               mem[wr_addr_i][8*i +: 8] <= wr_data_i[8*i +: 8];
         end
      end
   end

   // Host read, data one cycle after the request
   always_ff @(posedge MRxClk) begin
      if (rd_en_i)
         rd_data_o <= mem[rd_addr_i];
   end

endmodule

//--- hdl/eth_rx_core.sv
module eth_rx_core (
   input  logic                              MRxClk,
   input  logic                              ETH_PHY_RESETN,
   input  logic [3:0]                        MRxD_i,
   input  logic                              MRxDv_i,
   output logic                              frame_valid_o,
   input  logic                              frame_ready_i,
   output logic [eth_rx_pkg::BYTE_CNT_W-1:0] frame_size_o,
   output logic                              crc_ok_o,
   input  logic                              rd_en_i,
   input  logic [eth_rx_pkg::BUF_ADDR_W-1:0] rd_addr_i,
   output logic [31:0]                       rd_data_o,
   output logic                              phy_dv_detected_o
);
   import eth_rx_pkg::*;

   // Byte stream from the MII receiver
   logic       byte_valid;
   logic [7:0] byte_data;
   logic       frame_start;
   logic       frame_end;
   logic       crc_ok;

   // Buffer write port
   logic                  wr_en;
   logic [3:0]            wr_strb;
   logic [BUF_ADDR_W-1:0] wr_addr;
   logic [31:0]           wr_data;

   eth_rx_mii mii (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .mrxd_i        (MRxD_i),
      .mrxdv_i       (MRxDv_i),
      .byte_valid_o  (byte_valid),
      .byte_data_o   (byte_data),
      .frame_start_o (frame_start),
      .frame_end_o   (frame_end)
   );

   eth_rx_crc crc (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .init_i        (frame_start),
      .byte_valid_i  (byte_valid),
      .byte_data_i   (byte_data),
      .crc_ok_o      (crc_ok)
   );

   eth_rx_frame_ctrl frame_ctrl (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .frame_start_i (frame_start),
      .frame_end_i   (frame_end),
      .byte_valid_i  (byte_valid),
      .byte_data_i   (byte_data),
      .crc_ok_i      (crc_ok),
      .wr_en_o       (wr_en),
      .wr_strb_o     (wr_strb),
      .wr_addr_o     (wr_addr),
      .wr_data_o     (wr_data),
      .frame_valid_o (frame_valid_o),
      .frame_ready_i (frame_ready_i),
      .frame_size_o  (frame_size_o),
      .crc_ok_o      (crc_ok_o)
   );

   eth_rx_buffer rx_buffer (
      .MRxClk   (MRxClk),
      .wr_en_i  (wr_en),
      .wr_strb_i(wr_strb),
      .wr_addr_i(wr_addr),
      .wr_data_i(wr_data),
      .rd_en_i  (rd_en_i),
      .rd_addr_i(rd_addr_i),
      .rd_data_o(rd_data_o)
   );

   // Sticky, set once the PHY has driven data valid
   always_ff @(posedge MRxClk, negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN)
         phy_dv_detected_o <= 1'b0;
      else if (MRxDv_i)
         phy_dv_detected_o <= 1'b1;
   end

endmodule

//--- hdl/eth_rx_crc.sv
module eth_rx_crc (
   input  logic       MRxClk,
   input  logic       ETH_PHY_RESETN,
   input  logic       init_i,
   input  logic       byte_valid_i,
   input  logic [7:0] byte_data_i,
   output logic       crc_ok_o
);
   import eth_rx_pkg::*;

   logic [CRC_W-1:0] crc;

   // One byte, LSB first, eight shift steps
   function automatic logic [CRC_W-1:0] crc_byte(input logic [CRC_W-1:0] c,
                                                 input logic [7:0]       d);
      logic [CRC_W-1:0] r;
      r = c ^ {{(CRC_W-8){1'b0}}, d};
      for (int i = 0; i < 8; i++) begin
         if (r[0])
            r = (r >> 1) ^ CRC_POLY;
         else
            r = r >> 1;
      end
      return r;
   endfunction

   always_ff @(posedge MRxClk, negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN)
         crc <= CRC_INIT;
      else if (init_i)
         crc <= CRC_INIT;                      // Start of each frame
      else if (byte_valid_i)
         crc <= crc_byte(crc, byte_data_i);
   end

   // Residue is constant once the FCS has been shifted in
   assign crc_ok_o = (crc == CRC_RESIDUE);

endmodule

//--- hdl/eth_rx_frame_ctrl.sv
module eth_rx_frame_ctrl (
   input  logic                              MRxClk,
   input  logic                              ETH_PHY_RESETN,
   input  logic                              frame_start_i,
   input  logic                              frame_end_i,
   input  logic                              byte_valid_i,
   input  logic [7:0]                        byte_data_i,
   input  logic                              crc_ok_i,
   output logic                              wr_en_o,
   output logic [3:0]                        wr_strb_o,
   output logic [eth_rx_pkg::BUF_ADDR_W-1:0] wr_addr_o,
   output logic [31:0]                       wr_data_o,
   output logic                              frame_valid_o,
   input  logic                              frame_ready_i,
   output logic [eth_rx_pkg::BYTE_CNT_W-1:0] frame_size_o,
   output logic                              crc_ok_o
);
   import eth_rx_pkg::*;

   fc_state_t             state;
   logic [BYTE_CNT_W-1:0] byte_cnt;
   logic                  cnt_full;
   logic                  take;      // Byte goes to the buffer

   // Count saturates one short of the buffer so the size fits its field
   assign cnt_full = (int'(byte_cnt) >= MAX_FRAME_BYTES - 1);
   assign take     = (state == FC_RECV) && byte_valid_i && !cnt_full;

   always_ff @(posedge MRxClk, negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state         <= FC_IDLE;
         byte_cnt      <= '0;
         wr_en_o       <= 1'b0;
         frame_valid_o <= 1'b0;
         frame_size_o  <= '0;
         crc_ok_o      <= 1'b0;
      end else begin
         wr_en_o <= take;
         if (take)
            byte_cnt <= byte_cnt + 1'b1;
         if (frame_valid_o && frame_ready_i)
            frame_valid_o <= 1'b0;          // Host took the frame

         case (state)
            FC_IDLE: begin
               if (frame_start_i) begin
                  byte_cnt <= '0;
                  state    <= FC_RECV;
               end
            end
            FC_RECV: begin
               if (frame_end_i) begin
                  frame_size_o  <= byte_cnt;   // FCS included
                  crc_ok_o      <= crc_ok_i;
                  frame_valid_o <= 1'b1;
                  state         <= FC_HOLD;
               end
            end
            FC_HOLD: begin
               // Buffer still owned by the host, drop anything new
               if (frame_start_i)
                  state <= FC_DISCARD;
               else if (frame_ready_i)
                  state <= FC_IDLE;
            end
            FC_DISCARD: begin
               if (frame_end_i)
                  state <= (frame_valid_o && !frame_ready_i) ? FC_HOLD : FC_IDLE;
            end
            default: state <= FC_IDLE;
         endcase
      end
   end

   // Byte lane from the low count bits
   always_ff @(posedge MRxClk) begin
      if (take) begin
         wr_addr_o <= byte_cnt[BYTE_CNT_W-1:2];
         wr_strb_o <= 4'b0001 << byte_cnt[1:0];
         wr_data_o <= {24'd0, byte_data_i} << (8 * byte_cnt[1:0]);
      end
   end

endmodule

//--- hdl/eth_rx_mii.sv
module eth_rx_mii (
   input  logic       MRxClk,
   input  logic       ETH_PHY_RESETN,
   input  logic [3:0] mrxd_i,
   input  logic       mrxdv_i,
   output logic       byte_valid_o,
   output logic [7:0] byte_data_o,
   output logic       frame_start_o,
   output logic       frame_end_o
);
   import eth_rx_pkg::*;

   mii_state_t state;
   logic       dv_q;     // Data valid of the previous nibble
   logic       nib_hi;   // Low nibble already captured
   logic [3:0] nib_lo;

   always_ff @(posedge MRxClk, negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state         <= MII_IDLE;
         dv_q          <= 1'b0;
         nib_hi        <= 1'b0;
         byte_valid_o  <= 1'b0;
         frame_start_o <= 1'b0;
         frame_end_o   <= 1'b0;
      end else begin
         dv_q          <= mrxdv_i;
         byte_valid_o  <= 1'b0;
         frame_start_o <= 1'b0;
         frame_end_o   <= 1'b0;

         case (state)
            MII_IDLE: begin
               // Only the first nibble of a burst may open a frame,
               // so a rejected frame is ignored until MRxDv drops
               if (mrxdv_i && !dv_q && mrxd_i == PREAMBLE_NIB)
                  state <= MII_PREAMBLE;
            end
            MII_PREAMBLE: begin
               if (!mrxdv_i) begin
                  state <= MII_IDLE;
               end else if (mrxd_i == SFD_NIB) begin
                  state         <= MII_DATA;
                  nib_hi        <= 1'b0;
                  frame_start_o <= 1'b1;
               end else if (mrxd_i != PREAMBLE_NIB) begin
                  state <= MII_IDLE;   // Bad preamble
               end
            end
            MII_DATA: begin
               if (!mrxdv_i) begin
                  state       <= MII_IDLE;
                  nib_hi      <= 1'b0;   // Odd trailing nibble is lost
                  frame_end_o <= 1'b1;
               end else begin
                  nib_hi <= !nib_hi;
                  if (nib_hi)
                     byte_valid_o <= 1'b1;
               end
            end
            default: state <= MII_IDLE;
         endcase
      end
   end

   // Byte assembly
   always_ff @(posedge MRxClk) begin
      if (state == MII_DATA && mrxdv_i) begin
         if (nib_hi)
            byte_data_o <= {mrxd_i, nib_lo};
         else
            nib_lo <= mrxd_i;
      end
   end

endmodule

//--- hdl/eth_rx_pkg.sv
package eth_rx_pkg;

   // Receive buffer geometry
   localparam int BUF_ADDR_W      = 9;                // Word address
   localparam int BUF_WORDS       = 1 << BUF_ADDR_W;
   localparam int BYTE_CNT_W      = 11;               // Byte count and frame size
   localparam int MAX_FRAME_BYTES = 2048;

   // CRC-32, reflected form as sent on the wire
   localparam int CRC_W = 32;

   localparam logic [CRC_W-1:0] CRC_INIT    = 32'hFFFF_FFFF;
   localparam logic [CRC_W-1:0] CRC_POLY    = 32'hEDB8_8320;
   localparam logic [CRC_W-1:0] CRC_RESIDUE = 32'hDEBB_20E3; // After data plus FCS

   // MII nibbles, low nibble of each byte first
   localparam logic [3:0] PREAMBLE_NIB = 4'h5;
   localparam logic [3:0] SFD_NIB      = 4'hD;   // High nibble of 8'hD5

   typedef enum logic [1:0] {
      MII_IDLE,
      MII_PREAMBLE,
      MII_DATA
   } mii_state_t;

   // Frame controller
   typedef enum logic [1:0] {
      FC_IDLE,
      FC_RECV,      // Storing bytes
      FC_DISCARD,   // Dropping a frame until its end
      FC_HOLD       // Frame offered to host
   } fc_state_t;

endpackage

//--- list.f
hdl/eth_rx_pkg.sv
hdl/eth_rx_mii.sv
hdl/eth_rx_crc.sv
hdl/eth_rx_frame_ctrl.sv
hdl/eth_rx_buffer.sv
hdl/eth_rx_core.sv
sim/eth_rx_clkgen.sv
sim/eth_rx_assertions.sv
sim/eth_rx_tb.sv

//--- sim/eth_rx_assertions.sv
module eth_rx_assertions (
   input logic                              MRxClk,
   input logic                              ETH_PHY_RESETN,
   input logic                              frame_valid_i,
   input logic                              frame_ready_i,
   input logic [eth_rx_pkg::BYTE_CNT_W-1:0] frame_size_i,
   input logic                              wr_en_i,
   input logic [3:0]                        wr_strb_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // Offer stays up with a stable size until the host takes it
   valid_held: assert property (@(posedge MRxClk) disable iff (!ETH_PHY_RESETN)
      frame_valid_i && !frame_ready_i |=> frame_valid_i && $stable(frame_size_i))
      else $error("frame_valid_o or frame_size_o changed before frame_ready_i");

   strb_onehot: assert property (@(posedge MRxClk) disable iff (!ETH_PHY_RESETN)
      wr_en_i |-> $onehot(wr_strb_i))
      else $error("wr_strb_o is not one-hot during a buffer write");

   reset_quiet: assert property (@(posedge MRxClk)
      !ETH_PHY_RESETN |-> !frame_valid_i)
      else $error("frame_valid_o high during reset");

endmodule

bind eth_rx_core eth_rx_assertions handshake_checks (
   .MRxClk        (MRxClk),
   .ETH_PHY_RESETN(ETH_PHY_RESETN),
   .frame_valid_i (frame_valid_o),
   .frame_ready_i (frame_ready_i),
   .frame_size_i  (frame_size_o),
   .wr_en_i       (wr_en),
   .wr_strb_i     (wr_strb)
);

//--- sim/eth_rx_clkgen.sv
module eth_rx_clkgen (
   output logic MRxClk,
   output logic ETH_PHY_RESETN
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      MRxClk = 1'b0;
      forever #4 MRxClk = ~MRxClk;   // 8 ns period
   end

   initial begin
      ETH_PHY_RESETN = 1'b0;
      repeat (5) @(posedge MRxClk);
      @(negedge MRxClk);              // Release away from the active edge
      ETH_PHY_RESETN = 1'b1;
   end

endmodule

//--- sim/eth_rx_tb.sv
module eth_rx_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import eth_rx_pkg::*;

   typedef logic [7:0] byte_queue_t [$];

   localparam int MAX_LEN      = 300;
   localparam int RAND_FRAMES  = 20;
   localparam int DROP_LEN     = 40;
   localparam int IFG_CYCLES   = 24;   // 96 bit times
   localparam int HOLD_DELAY   = 2 * (12 + DROP_LEN) + 2 * IFG_CYCLES + 40;
   localparam int FRAME_CYCLES = 2 * (12 + MAX_LEN) + IFG_CYCLES + HOLD_DELAY
                                 + 2 * ((MAX_LEN + 7) / 4) + 8;
   localparam int CYCLE_LIMIT  = (6 + RAND_FRAMES) * FRAME_CYCLES + 100;

   logic                  MRxClk;
   logic                  ETH_PHY_RESETN;
   logic [3:0]            mrxd;
   logic                  mrxdv;
   logic                  frame_valid;
   logic                  frame_ready;
   logic [BYTE_CNT_W-1:0] frame_size;
   logic                  crc_ok;
   logic                  rd_en;
   logic [BUF_ADDR_W-1:0] rd_addr;
   logic [31:0]           rd_data;
   logic                  phy_dv_detected;

   int          seed = 32'h33c4_4f0f;
   int          errors;
   int          cycle_count;
   int          host_delay;
   int          frames_done;
   int          expected_frames;
   byte_queue_t tx_q;        // Frame body as sent with its FCS
   logic        tx_crc_ok;
   byte_queue_t exp_q;       // Frame the host should see next
   logic        exp_crc_ok;

   eth_rx_clkgen clkgen (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN)
   );

   eth_rx_core UUT (
      .MRxClk           (MRxClk),
      .ETH_PHY_RESETN   (ETH_PHY_RESETN),
      .MRxD_i           (mrxd),
      .MRxDv_i          (mrxdv),
      .frame_valid_o    (frame_valid),
      .frame_ready_i    (frame_ready),
      .frame_size_o     (frame_size),
      .crc_ok_o         (crc_ok),
      .rd_en_i          (rd_en),
      .rd_addr_i        (rd_addr),
      .rd_data_o        (rd_data),
      .phy_dv_detected_o(phy_dv_detected)
   );

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expv);
      if (got !== expv) begin
         errors++;
         $display("MISMATCH %s got %h expected %h at %0t", name, got, expv, $time);
      end
   endtask

   // IEEE 802.3 FCS computed one bit at a time
   function automatic logic [31:0] ref_fcs(input byte_queue_t data);
      logic [31:0] crc;
      logic        fb;
      crc = CRC_INIT;
      foreach (data[i]) begin
         for (int b = 0; b < 8; b++) begin
            fb  = crc[0] ^ data[i][b];
            crc = crc >> 1;
            if (fb)
               crc = crc ^ CRC_POLY;
         end
      end
      return ~crc;
   endfunction

   task automatic make_frame(input int len, input bit flip);
      byte_queue_t payload;
      logic [31:0] fcs;
      int          pos;
      payload = {};
      for (int i = 0; i < len; i++)
         payload.push_back(8'($random(seed)));
      fcs = ref_fcs(payload);
      if (flip) begin
         pos = int'($unsigned($random(seed)) % (len * 8));
         payload[pos / 8] = payload[pos / 8] ^ (8'h01 << (pos % 8));   // Corrupt after FCS
      end
      tx_crc_ok = (ref_fcs(payload) == fcs);
      tx_q      = payload;
      for (int k = 0; k < 4; k++)
         tx_q.push_back(fcs[8*k +: 8]);
   endtask

   task automatic expect_frame();
      exp_q      = tx_q;
      exp_crc_ok = tx_crc_ok;
      expected_frames++;
   endtask

   task automatic drive_nibble(input logic [3:0] nib);
      @(negedge MRxClk);
      mrxdv = 1'b1;
      mrxd  = nib;
   endtask

   // Preamble, SFD and body go out low nibble first
   task automatic send_frame();
      logic [7:0] b;
      for (int i = 0; i < 8 + tx_q.size(); i++) begin
         b = (i < 7) ? 8'h55 : (i == 7) ? 8'hD5 : tx_q[i-8];
         drive_nibble(b[3:0]);
         drive_nibble(b[7:4]);
      end
      @(negedge MRxClk);
      mrxdv = 1'b0;
      mrxd  = 4'h0;
      repeat (IFG_CYCLES) @(negedge MRxClk);
   endtask

   task automatic wait_host();
      wait (frames_done == expected_frames);
      @(negedge MRxClk);
   endtask

   task automatic read_buffer();
      logic [31:0] exp_word;
      logic [31:0] mask;
      for (int w = 0; w < (exp_q.size() + 3) / 4; w++) begin
         exp_word = '0;
         mask     = '0;
         for (int k = 0; k < 4; k++) begin
            if (4 * w + k < exp_q.size()) begin
               exp_word[8*k +: 8] = exp_q[4*w + k];
               mask[8*k +: 8]     = 8'hFF;   // Lanes past the end are stale
            end
         end
         @(negedge MRxClk);
         rd_en   = 1'b1;
         rd_addr = BUF_ADDR_W'(w);
         @(negedge MRxClk);
         rd_en = 1'b0;
         check_value($sformatf("rd_data_o[%0d]", w), rd_data & mask, exp_word);
      end
   endtask

   // Host side that compares every offered frame with the model
   initial begin : host_compare
      frame_ready = 1'b0;
      rd_en       = 1'b0;
      rd_addr     = '0;
      forever begin
         @(negedge MRxClk);
         if (frame_valid) begin
            repeat (host_delay) @(negedge MRxClk);
            check_value("frame_size_o", 32'(frame_size), 32'(exp_q.size()));
            check_value("crc_ok_o", 32'(crc_ok), 32'(exp_crc_ok));
            read_buffer();
            frame_ready = 1'b1;
            @(negedge MRxClk);
            frame_ready = 1'b0;
            frames_done++;
         end
      end
   end

   initial begin : stimulus
      mrxd       = 4'h0;
      mrxdv      = 1'b0;
      host_delay = 2;
      @(posedge ETH_PHY_RESETN);
      @(negedge MRxClk);
      check_value("frame_valid_o", 32'(frame_valid), 32'd0);
      check_value("crc_ok_o", 32'(crc_ok), 32'd0);
      check_value("phy_dv_detected_o", 32'(phy_dv_detected), 32'd0);
      check_value("frame_size_o", 32'(frame_size), 32'd0);

      make_frame(64, 1'b0);   // Good frame
      expect_frame();
      send_frame();
      wait_host();
      check_value("phy_dv_detected_o", 32'(phy_dv_detected), 32'd1);

      make_frame(61, 1'b1);   // Bad FCS
      expect_frame();
      send_frame();
      wait_host();

      // Held frame and then one that arrives during the hold
      host_delay = HOLD_DELAY;
      make_frame(50, 1'b0);
      expect_frame();
      send_frame();
      check_value("frame_valid_o", 32'(frame_valid), 32'd1);
      make_frame(DROP_LEN, 1'b1);   // Bad FCS
      send_frame();
      wait_host();
      check_value("frame_valid_o", 32'(frame_valid), 32'd0);
      host_delay = 2;
      make_frame(30, 1'b0);
      expect_frame();
      send_frame();
      wait_host();

      for (int n = 0; n < RAND_FRAMES; n++) begin
         host_delay = int'($unsigned($random(seed)) % 16);
         make_frame(1 + int'($unsigned($random(seed)) % MAX_LEN), 1'b0);
         expect_frame();
         send_frame();
         wait_host();
      end

      $display("Frames checked: %0d, errors: %0d", frames_done, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   initial begin : watchdog
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge MRxClk);
         cycle_count++;
      end
      $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Frames checked: %0d, errors: %0d", frames_done, errors);
      $display("TB FAILED");
      $finish;
   end

endmodule
